/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
SEED      ?= 1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o sim -f build.f
	@out=$$(./$(OBJ_DIR)/sim +verilator+seed+$(SEED) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
source/bus_pkg.sv
source/clint_read_if.sv
source/bus_arbiter.sv
source/clint_timer.sv
source/soc_bus_top.sv
tests/soc_bus_properties.sv
tests/tb_soc_bus.sv

/* source/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                             clock,
  input  logic                             reset,

  input  logic [bus_pkg::addr_width-1:0]   araddr_0,
  input  logic                             arvalid_0,
  output logic                             arready_0,
  input  logic                             rready_0,
  output logic [bus_pkg::data_width-1:0]   rdata_0,
  output logic [bus_pkg::resp_width-1:0]   rresp_0,
  output logic                             rvalid_0,

  input  logic [bus_pkg::addr_width-1:0]   araddr_1,
  input  logic                             arvalid_1,
  output logic                             arready_1,
  input  logic                             rready_1,
  output logic [bus_pkg::data_width-1:0]   rdata_1,
  output logic [bus_pkg::resp_width-1:0]   rresp_1,
  output logic                             rvalid_1,
  input  logic [bus_pkg::addr_width-1:0]   awaddr_1,
  input  logic                             awvalid_1,
  output logic                             awready_1,
  input  logic [bus_pkg::data_width-1:0]   wdata_1,
  input  logic [bus_pkg::strb_width-1:0]   wstrb_1,
  input  logic                             wvalid_1,
  output logic                             wready_1,
  input  logic                             bready_1,
  output logic [bus_pkg::resp_width-1:0]   bresp_1,
  output logic                             bvalid_1,

  output logic [bus_pkg::addr_width-1:0]   mem_araddr,
  output logic                             mem_arvalid,
  input  logic                             mem_arready,
  input  logic [bus_pkg::data_width-1:0]   mem_rdata,
  input  logic [bus_pkg::resp_width-1:0]   mem_rresp,
  input  logic                             mem_rvalid,
  output logic                             mem_rready,
  output logic [bus_pkg::addr_width-1:0]   mem_awaddr,
  output logic                             mem_awvalid,
  input  logic                             mem_awready,
  output logic [bus_pkg::data_width-1:0]   mem_wdata,
  output logic [bus_pkg::strb_width-1:0]   mem_wstrb,
  output logic                             mem_wvalid,
  input  logic                             mem_wready,
  input  logic [bus_pkg::resp_width-1:0]   mem_bresp,
  input  logic                             mem_bvalid,
  output logic                             mem_bready,

  clint_read_if.arbiter                    clint
);
  import bus_pkg::*;

  arb_state_e state;
  grant_e     grant;
  target_e    target;
  logic       lsu_write;  // lsu grant came from awvalid_1

  logic                  fetch_sel;
  logic                  lsu_rd_sel;
  logic                  lsu_wr_sel;
  logic                  lsu_clint_hit;
  logic                  done;

  // read request of whichever master holds a read grant
  logic [addr_width-1:0] rd_addr;
  logic                  rd_valid;
  logic                  rd_ready;
  // read response from whichever slave was targeted
  logic                  rd_addr_ready;
  logic [data_width-1:0] rd_data;
  logic [resp_width-1:0] rd_resp;
  logic                  rd_data_valid;

  assign fetch_sel  = (grant == grant_fetch);
  assign lsu_rd_sel = (grant == grant_lsu) && !lsu_write;
  assign lsu_wr_sel = (grant == grant_lsu) && lsu_write;

  assign lsu_clint_hit = (araddr_1 == clint_mtime_lo_addr) || (araddr_1 == clint_mtime_hi_addr);

  always_comb begin
    rd_addr  = '0;
    rd_valid = 1'b0;
    rd_ready = 1'b0;
    if (fetch_sel) begin
      rd_addr  = araddr_0;
      rd_valid = arvalid_0;
      rd_ready = rready_0;
    end else if (lsu_rd_sel) begin
      rd_addr  = araddr_1;
      rd_valid = arvalid_1;
      rd_ready = rready_1;
    end
  end

  always_comb begin
    mem_araddr    = '0;
    mem_arvalid   = 1'b0;
    mem_rready    = 1'b0;
    clint.araddr  = '0;
    clint.arvalid = 1'b0;
    clint.rready  = 1'b0;
    rd_addr_ready = 1'b0;
    rd_data       = '0;
    rd_resp       = '0;
    rd_data_valid = 1'b0;
    case (target)
      target_mem: begin
        mem_araddr    = rd_addr;
        mem_arvalid   = rd_valid;
        mem_rready    = rd_ready;
        rd_addr_ready = mem_arready;
        rd_data       = mem_rdata;
        rd_resp       = mem_rresp;
        rd_data_valid = mem_rvalid;
      end
      target_clint: begin
        clint.araddr  = rd_addr;
        clint.arvalid = rd_valid;
        clint.rready  = rd_ready;
        rd_addr_ready = clint.arready;
        rd_data       = clint.rdata;
        rd_resp       = clint.rresp;
        rd_data_valid = clint.rvalid;
      end
      default: ;
    endcase
  end

  always_comb begin
    arready_0 = 1'b0;
    rdata_0   = '0;
    rresp_0   = '0;
    rvalid_0  = 1'b0;
    arready_1 = 1'b0;
    rdata_1   = '0;
    rresp_1   = '0;
    rvalid_1  = 1'b0;
    if (fetch_sel) begin
      arready_0 = rd_addr_ready;
      rdata_0   = rd_data;
      rresp_0   = rd_resp;
      rvalid_0  = rd_data_valid;
    end else if (lsu_rd_sel) begin
      arready_1 = rd_addr_ready;
      rdata_1   = rd_data;
      rresp_1   = rd_resp;
      rvalid_1  = rd_data_valid;
    end
  end

  // writes only ever go to the external port
  always_comb begin
    mem_awaddr  = '0;
    mem_awvalid = 1'b0;
    mem_wdata   = '0;
    mem_wstrb   = '0;
    mem_wvalid  = 1'b0;
    mem_bready  = 1'b0;
    awready_1   = 1'b0;
    wready_1    = 1'b0;
    bresp_1     = '0;
    bvalid_1    = 1'b0;
    if (lsu_wr_sel && target == target_mem) begin
      mem_awaddr  = awaddr_1;
      mem_awvalid = awvalid_1;
      mem_wdata   = wdata_1;
      mem_wstrb   = wstrb_1;
      mem_wvalid  = wvalid_1;
      mem_bready  = bready_1;
      awready_1   = mem_awready;
      wready_1    = mem_wready;
      bresp_1     = mem_bresp;
      bvalid_1    = mem_bvalid;
    end
  end

  assign done = (target == target_mem
                 && ((mem_rvalid && mem_rready) || (mem_bvalid && mem_bready)))
             || (target == target_clint && clint.rvalid && clint.rready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= arb_idle;
      grant     <= grant_none;
      target    <= target_none;
      lsu_write <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (arvalid_0) begin
            state     <= arb_transfer;
            grant     <= grant_fetch;
            target    <= target_mem;
            lsu_write <= 1'b0;
          end else if (arvalid_1) begin
            state     <= arb_transfer;
            grant     <= grant_lsu;
            target    <= lsu_clint_hit ? target_clint : target_mem;
            lsu_write <= 1'b0;
          end else if (awvalid_1) begin
            state     <= arb_transfer;
            grant     <= grant_lsu;
            target    <= target_mem;
            lsu_write <= 1'b1;
          end
        end
        arb_transfer: begin
          if (done) begin  // final handshake releases the bus for one idle cycle
            state  <= arb_idle;
            grant  <= grant_none;
            target <= target_none;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

endmodule

/* source/bus_pkg.sv */
package bus_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = 4;
  localparam int resp_width = 2;

  localparam logic [resp_width-1:0] resp_okay = 2'b00;

  // mtime is split over two word addresses in the CLINT window
  localparam logic [addr_width-1:0] clint_mtime_lo_addr = 32'ha000_0048;
  localparam logic [addr_width-1:0] clint_mtime_hi_addr = 32'ha000_004c;

  typedef enum logic {
    arb_idle,
    arb_transfer
  } arb_state_e;

  // owner of the shared bus for the current transaction
  typedef enum logic [1:0] {
    grant_none,
    grant_fetch,
    grant_lsu
  } grant_e;

  typedef enum logic [1:0] {
    target_none,
    target_clint,
    target_mem
  } target_e;

endpackage

/* source/clint_read_if.sv */
`timescale 1ns/1ps

interface clint_read_if;
  import bus_pkg::*;

  logic [addr_width-1:0] araddr;
  logic                  arvalid;
  logic                  arready;

  logic                  rready;
  logic [data_width-1:0] rdata;
  logic [resp_width-1:0] rresp;
  logic                  rvalid;

  modport arbiter (
    output araddr,
    output arvalid,
    input  arready,
    output rready,
    input  rdata,
    input  rresp,
    input  rvalid
  );

  modport timer (
    input  araddr,
    input  arvalid,
    output arready,
    input  rready,
    output rdata,
    output rresp,
    output rvalid
  );

endinterface

/* source/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer (
  input  logic          clock,
  input  logic          reset,
  clint_read_if.timer   bus
);
  import bus_pkg::*;

  logic [63:0]           mtime;
  logic                  pending;  // a response is waiting for rready
  logic [data_width-1:0] rdata_q;
  logic                  addr_hs;
  logic                  data_hs;

  assign addr_hs = bus.arvalid && bus.arready;
  assign data_hs = bus.rvalid && bus.rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (addr_hs) begin
      pending <= 1'b1;
    end else if (data_hs) begin
      pending <= 1'b0;
    end
  end

  // any address other than the high word reads the low half
  always_ff @(posedge clock) begin
    if (addr_hs) begin
      if (bus.araddr == clint_mtime_hi_addr) begin
        rdata_q <= mtime[63:32];
      end else begin
        rdata_q <= mtime[31:0];
      end
    end
  end

  assign bus.arready = !pending;
  assign bus.rvalid  = pending;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = resp_okay;  // mtime reads cannot fail

endmodule

/* source/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top (
  input  logic                             clock,
  input  logic                             reset,

  input  logic [bus_pkg::addr_width-1:0]   araddr_0,
  input  logic                             arvalid_0,
  output logic                             arready_0,
  input  logic                             rready_0,
  output logic [bus_pkg::data_width-1:0]   rdata_0,
  output logic [bus_pkg::resp_width-1:0]   rresp_0,
  output logic                             rvalid_0,

  input  logic [bus_pkg::addr_width-1:0]   araddr_1,
  input  logic                             arvalid_1,
  output logic                             arready_1,
  input  logic                             rready_1,
  output logic [bus_pkg::data_width-1:0]   rdata_1,
  output logic [bus_pkg::resp_width-1:0]   rresp_1,
  output logic                             rvalid_1,
  input  logic [bus_pkg::addr_width-1:0]   awaddr_1,
  input  logic                             awvalid_1,
  output logic                             awready_1,
  input  logic [bus_pkg::data_width-1:0]   wdata_1,
  input  logic [bus_pkg::strb_width-1:0]   wstrb_1,
  input  logic                             wvalid_1,
  output logic                             wready_1,
  input  logic                             bready_1,
  output logic [bus_pkg::resp_width-1:0]   bresp_1,
  output logic                             bvalid_1,

  output logic [bus_pkg::addr_width-1:0]   mem_araddr,
  output logic                             mem_arvalid,
  input  logic                             mem_arready,
  input  logic [bus_pkg::data_width-1:0]   mem_rdata,
  input  logic [bus_pkg::resp_width-1:0]   mem_rresp,
  input  logic                             mem_rvalid,
  output logic                             mem_rready,
  output logic [bus_pkg::addr_width-1:0]   mem_awaddr,
  output logic                             mem_awvalid,
  input  logic                             mem_awready,
  output logic [bus_pkg::data_width-1:0]   mem_wdata,
  output logic [bus_pkg::strb_width-1:0]   mem_wstrb,
  output logic                             mem_wvalid,
  input  logic                             mem_wready,
  input  logic [bus_pkg::resp_width-1:0]   mem_bresp,
  input  logic                             mem_bvalid,
  output logic                             mem_bready
);

  clint_read_if clint_bus ();

  bus_arbiter u_arbiter (
    .clock       (clock),
    .reset       (reset),
    .araddr_0    (araddr_0),
    .arvalid_0   (arvalid_0),
    .arready_0   (arready_0),
    .rready_0    (rready_0),
    .rdata_0     (rdata_0),
    .rresp_0     (rresp_0),
    .rvalid_0    (rvalid_0),
    .araddr_1    (araddr_1),
    .arvalid_1   (arvalid_1),
    .arready_1   (arready_1),
    .rready_1    (rready_1),
    .rdata_1     (rdata_1),
    .rresp_1     (rresp_1),
    .rvalid_1    (rvalid_1),
    .awaddr_1    (awaddr_1),
    .awvalid_1   (awvalid_1),
    .awready_1   (awready_1),
    .wdata_1     (wdata_1),
    .wstrb_1     (wstrb_1),
    .wvalid_1    (wvalid_1),
    .wready_1    (wready_1),
    .bready_1    (bready_1),
    .bresp_1     (bresp_1),
    .bvalid_1    (bvalid_1),
    .mem_araddr  (mem_araddr),
    .mem_arvalid (mem_arvalid),
    .mem_arready (mem_arready),
    .mem_rdata   (mem_rdata),
    .mem_rresp   (mem_rresp),
    .mem_rvalid  (mem_rvalid),
    .mem_rready  (mem_rready),
    .mem_awaddr  (mem_awaddr),
    .mem_awvalid (mem_awvalid),
    .mem_awready (mem_awready),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_wvalid  (mem_wvalid),
    .mem_wready  (mem_wready),
    .mem_bresp   (mem_bresp),
    .mem_bvalid  (mem_bvalid),
    .mem_bready  (mem_bready),
    .clint       (clint_bus.arbiter)
  );

  clint_timer u_timer (
    .clock (clock),
    .reset (reset),
    .bus   (clint_bus.timer)
  );

endmodule

/* tests/soc_bus_properties.sv */
`timescale 1ns/1ps

module soc_bus_properties (
  input logic               clock,
  input logic               reset,
  input bus_pkg::arb_state_e state,
  input bus_pkg::grant_e    grant,
  input logic               done,
  input logic               rvalid_0,
  input logic               rvalid_1,
  input logic               mem_arvalid,
  input logic               mem_awvalid
);
  import bus_pkg::*;

  int failures = 0;

  one_read_response: assert property (@(posedge clock) disable iff (reset)
    !(rvalid_0 && rvalid_1)) else begin
    $error("both masters see rvalid");
    failures++;
  end

  one_mem_request: assert property (@(posedge clock) disable iff (reset)
    !(mem_arvalid && mem_awvalid)) else begin
    $error("read and write requests overlap");
    failures++;
  end

  reset_clears_grant: assert property (@(posedge clock)
    reset |=> grant == grant_none) else begin
    $error("grant not cleared by reset");
    failures++;
  end

  // the owner may only change at the closing handshake
  grant_held: assert property (@(posedge clock) disable iff (reset)
    (state == arb_transfer && !done) |=> $stable(grant)) else begin
    $error("grant changed early");
    failures++;
  end

endmodule

bind bus_arbiter soc_bus_properties u_properties (.*);

/* tests/tb_soc_bus.sv */
`timescale 1ns/1ps

module tb_soc_bus;
  import bus_pkg::*;

  typedef struct {
    int          kind;    // 0 fetch read, 1 lsu read, 2 lsu write, 3 fetch and lsu read at once
    logic [31:0] addr;
    logic [31:0] addr2;   // lsu address of a paired read
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    int          source;  // 0 memory, 1 mtime low word, 2 mtime high word
  } row_t;

  logic clock, reset;
  logic [addr_width-1:0] araddr_0, araddr_1, awaddr_1, mem_araddr, mem_awaddr;
  logic [data_width-1:0] rdata_0, rdata_1, wdata_1, mem_rdata, mem_wdata;
  logic [resp_width-1:0] rresp_0, rresp_1, bresp_1, mem_rresp, mem_bresp;
  logic [strb_width-1:0] wstrb_1, mem_wstrb;
  logic arvalid_0, arready_0, rready_0, rvalid_0;
  logic arvalid_1, arready_1, rready_1, rvalid_1;
  logic awvalid_1, awready_1, wvalid_1, wready_1, bready_1, bvalid_1;
  logic mem_arvalid, mem_arready, mem_rvalid, mem_rready;
  logic mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;

  int          cycle = 0;
  logic [31:0] seen_araddr[$];  // read addresses in the order the memory accepted them
  logic [31:0] last_awaddr, last_wdata;
  logic [3:0]  last_wstrb;
  logic [1:0]  last_resp;
  row_t        rows[8];

  soc_bus_top DUT (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(negedge clock) cycle <= cycle + 1;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic lsu_outputs_idle();
    check_value("arready_1", 32'(arready_1), 0);
    check_value("rvalid_1", 32'(rvalid_1), 0);
    check_value("rdata_1", rdata_1, 0);
    check_value("rresp_1", 32'(rresp_1), 0);
    check_value("awready_1", 32'(awready_1), 0);
    check_value("wready_1", 32'(wready_1), 0);
    check_value("bresp_1", 32'(bresp_1), 0);
    check_value("bvalid_1", 32'(bvalid_1), 0);
  endtask

  task automatic serve_read();
    logic [31:0] addr;
    int t;
    repeat ($urandom_range(3, 0)) @(negedge clock);
    addr = mem_araddr;
    seen_araddr.push_back(addr);
    mem_arready = 1'b1;
    @(negedge clock);
    mem_arready = 1'b0;
    last_resp   = 2'($urandom_range(3, 0));
    mem_rdata   = addr ^ 32'h5a5a_5a5a;
    mem_rresp   = last_resp;
    mem_rvalid  = 1'b1;
    t = 0;
    while (!mem_rready && t < 50) begin
      @(negedge clock);
      t++;
    end
    if (!mem_rready) stop_run("memory read data was never accepted");
    @(negedge clock);
    mem_rvalid = 1'b0;
  endtask

  task automatic serve_write();
    int t;
    repeat ($urandom_range(3, 0)) @(negedge clock);
    last_awaddr = mem_awaddr;
    last_wdata  = mem_wdata;
    last_wstrb  = mem_wstrb;
    check_value("mem_wvalid", 32'(mem_wvalid), 1);
    mem_awready = 1'b1;
    mem_wready  = 1'b1;
    @(negedge clock);
    mem_awready = 1'b0;
    mem_wready  = 1'b0;
    last_resp   = 2'($urandom_range(3, 0));
    mem_bresp   = last_resp;
    mem_bvalid  = 1'b1;
    t = 0;
    while (!mem_bready && t < 50) begin
      @(negedge clock);
      t++;
    end
    if (!mem_bready) stop_run("write response was never accepted");
    @(negedge clock);
    mem_bvalid = 1'b0;
  endtask

  // memory model on the external port, one transaction at a time
  initial begin
    void'($urandom(32'hcf30_7db0));
    {mem_arready, mem_rvalid, mem_awready, mem_wready, mem_bvalid} = '0;
    {mem_rdata, mem_rresp, mem_bresp} = '0;
    forever begin
      @(negedge clock);
      if (mem_arvalid) serve_read();
      else if (mem_awvalid) serve_write();
    end
  end

  task automatic fetch_read(input logic [31:0] addr, input bit lsu_idle,
                            output logic [31:0] data, output logic [1:0] resp, output int done);
    int t;
    @(negedge clock);
    araddr_0  = addr;
    arvalid_0 = 1'b1;
    rready_0  = 1'b1;
    t = 0;
    do begin
      @(posedge clock);
      t++;
      if (lsu_idle) lsu_outputs_idle();
    end while (!arready_0 && t < 50);
    if (!arready_0) stop_run("fetch address was never accepted");
    @(negedge clock);
    arvalid_0 = 1'b0;
    t = 0;
    do begin
      @(posedge clock);
      t++;
      if (lsu_idle) lsu_outputs_idle();
    end while (!rvalid_0 && t < 50);
    if (!rvalid_0) stop_run("fetch read data never arrived");
    data = rdata_0;
    resp = rresp_0;
    done = cycle;
    @(negedge clock);
    rready_0 = 1'b0;
  endtask

  task automatic lsu_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp, output int hs, output int done);
    int t;
    bit clint_hit;
    clint_hit = (addr == clint_mtime_lo_addr) || (addr == clint_mtime_hi_addr);
    @(negedge clock);
    araddr_1  = addr;
    arvalid_1 = 1'b1;
    rready_1  = 1'b1;
    t = 0;
    do begin
      @(posedge clock);
      t++;
      if (clint_hit) check_value("mem_arvalid", 32'(mem_arvalid), 0);
    end while (!arready_1 && t < 50);
    if (!arready_1) stop_run("lsu read address was never accepted");
    hs = cycle;
    @(negedge clock);
    arvalid_1 = 1'b0;
    t = 0;
    do begin
      @(posedge clock);
      t++;
      if (clint_hit) check_value("mem_arvalid", 32'(mem_arvalid), 0);
    end while (!rvalid_1 && t < 50);
    if (!rvalid_1) stop_run("lsu read data never arrived");
    data = rdata_1;
    resp = rresp_1;
    done = cycle;
    @(negedge clock);
    rready_1 = 1'b0;
  endtask

  task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int t;
    @(negedge clock);
    {awaddr_1, wdata_1, wstrb_1} = {addr, data, strb};
    {awvalid_1, wvalid_1, bready_1} = 3'b111;
    t = 0;
    do begin
      @(posedge clock);
      t++;
    end while (!awready_1 && t < 50);
    if (!awready_1) stop_run("lsu write address was never accepted");
    check_value("wready_1", 32'(wready_1), 1);
    @(negedge clock);
    {awvalid_1, wvalid_1} = 2'b00;
    t = 0;
    do begin
      @(posedge clock);
      t++;
    end while (!bvalid_1 && t < 50);
    if (!bvalid_1) stop_run("write response never arrived");
    resp = bresp_1;
    @(negedge clock);
    bready_1 = 1'b0;
  endtask

  initial begin
    logic [31:0] data0, data1, prev_lo;
    logic [1:0]  resp0, resp1;
    int          c0, c1, hs, prev_hs;
    bit          have_lo;
    have_lo = 1'b0;
    reset = 1'b1;
    {araddr_0, arvalid_0, rready_0, araddr_1, arvalid_1, rready_1} = '0;
    {awaddr_1, awvalid_1, wdata_1, wstrb_1, wvalid_1, bready_1} = '0;
    rows[0] = '{0, 32'h0000_1000, 32'h0, 32'h0, 4'h0, 0};
    rows[1] = '{2, 32'h0000_2004, 32'h0, 32'hdead_beef, 4'hf, 0};
    rows[2] = '{1, clint_mtime_lo_addr, 32'h0, 32'h0, 4'h0, 1};
    rows[3] = '{1, clint_mtime_lo_addr, 32'h0, 32'h0, 4'h0, 1};
    rows[4] = '{1, clint_mtime_hi_addr, 32'h0, 32'h0, 4'h0, 2};
    rows[5] = '{3, 32'h0000_3000, 32'h0000_3010, 32'h0, 4'h0, 0};
    rows[6] = '{2, clint_mtime_lo_addr, 32'h0, 32'h1234_5678, 4'h3, 0};
    rows[7] = '{1, 32'h0000_4008, 32'h0, 32'h0, 4'h0, 0};
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    repeat (3) begin
      @(posedge clock);
      check_value("valid and ready outputs", 32'({mem_arvalid, mem_awvalid, mem_wvalid,
        mem_rready, mem_bready, arready_0, rvalid_0, arready_1, rvalid_1, awready_1,
        wready_1, bvalid_1}), 0);
    end
    for (int i = 0; i < 8; i++) begin
      case (rows[i].kind)
        0: begin
          fetch_read(rows[i].addr, 1'b1, data0, resp0, c0);
          check_value("rdata_0", data0, rows[i].addr ^ 32'h5a5a_5a5a);
          check_value("rresp_0", 32'(resp0), 32'(last_resp));
        end
        1: begin
          lsu_read(rows[i].addr, data1, resp1, hs, c1);
          if (rows[i].source == 0) begin
            check_value("rdata_1", data1, rows[i].addr ^ 32'h5a5a_5a5a);
            check_value("rresp_1", 32'(resp1), 32'(last_resp));
          end else begin
            check_value("rresp_1", 32'(resp1), 32'(resp_okay));
          end
          if (rows[i].source == 2) check_value("rdata_1", data1, 0);
          if (rows[i].source == 1 && have_lo)
            check_value("mtime low delta", data1 - prev_lo, 32'(hs - prev_hs));
          if (rows[i].source == 1) begin
            prev_lo = data1;
            prev_hs = hs;
            have_lo = 1'b1;
          end
        end
        2: begin
          lsu_write(rows[i].addr, rows[i].wdata, rows[i].wstrb, resp1);
          check_value("mem_awaddr", last_awaddr, rows[i].addr);
          check_value("mem_wdata", last_wdata, rows[i].wdata);
          check_value("mem_wstrb", 32'(last_wstrb), 32'(rows[i].wstrb));
          check_value("bresp_1", 32'(resp1), 32'(last_resp));
        end
        default: begin
          seen_araddr.delete();
          fork
            fetch_read(rows[i].addr, 1'b0, data0, resp0, c0);
            lsu_read(rows[i].addr2, data1, resp1, hs, c1);
          join
          check_value("first mem_araddr", seen_araddr[0], rows[i].addr);
          check_value("rdata_0", data0, rows[i].addr ^ 32'h5a5a_5a5a);
          check_value("rdata_1", data1, rows[i].addr2 ^ 32'h5a5a_5a5a);
          assert (c1 > c0) else stop_run("lsu read finished before the fetch read");
        end
      endcase
    end
    if (DUT.u_arbiter.u_properties.failures != 0) begin
      stop_run("a bound property on the arbiter failed");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
